// File: hawk_pgrd.f
hawk_pgrd_pkg.sv
lkup_front.sv
lkup_queue.sv
pgrd_mngr.sv
tbl_store.sv
hawk_pgrd.sv
hawk_pgrd_props.sv
tb_hawk_pgrd.sv

// File: tb_hawk_pgrd.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the page read top that checks LFSR traffic against a table model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_hawk_pgrd;
  import hawk_pgrd_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int TOTAL_LKUPS   = 300;
  localparam int WORST_CYC     = 24;            // alloc path plus stalls per lookup
  localparam int MARGIN_CYC    = 400;           // resets and the long stall
  localparam int MAX_IN_FLIGHT = QUEUE_DEPTH + 2; // queue, front slice, manager

  logic        clk_i;
  logic        rst_ni;
  lkup_req_t   lkup;
  logic        lkup_valid;
  logic        lkup_ready;
  trnsl_resp_t resp;
  logic        resp_valid;
  logic        resp_ready;

  logic [15:0]      lfsr = 16'd27;
  logic             m_alloc [ATT_ENTRIES];      // model ATT allocated flags
  logic [WAY_W-1:0] m_way [ATT_ENTRIES];
  int               m_used;                     // free ways handed out
  trnsl_resp_t      exp_q [$];                  // predictions in lookup order
  trnsl_resp_t      exp_r;
  int               n_sent;
  int               kind_seen [4] = '{default: 0};
  logic             lkup_fire;                  // transfer at the coming edge
  logic             blocked_seen;

  hawk_pgrd dut0 (
    .clk_i, .rst_ni, .lkup, .lkup_valid, .lkup_ready, .resp, .resp_valid, .resp_ready
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // galois form with taps 16 14 13 11
  function automatic logic next_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) lfsr = lfsr ^ 16'hB400;
    return lsb;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[14:0], next_bit()};
    return v;
  endfunction

  // about one page in eight falls outside the window on either side
  function automatic logic [HPPA_W-1:0] pick_hppa();
    logic [HPPA_W-1:0] p;
    if (rand_bits(3) != 0) p = HPPA_BASE + HPPA_W'(rand_bits(ATT_ID_W));
    else if (next_bit()) p = HPPA_BASE + HPPA_W'(ATT_ENTRIES) + HPPA_W'(rand_bits(8));
    else p = HPPA_BASE - 12'd1 - HPPA_W'(rand_bits(8));
    return p;
  endfunction

  function automatic trnsl_resp_t predict(input logic [HPPA_W-1:0] hppa);
    trnsl_resp_t      r;
    logic [ATT_ID_W-1:0] id;
    r.hppa = hppa;
    r.way  = '0;
    id     = ATT_ID_W'(hppa - HPPA_BASE);
    if (hppa < HPPA_BASE || hppa >= HPPA_BASE + HPPA_W'(ATT_ENTRIES)) begin
      r.kind = RESP_RANGE;
    end else if (m_alloc[id]) begin
      r.kind = RESP_HIT;
      r.way  = m_way[id];
    end else if (m_used < FREE_WAYS) begin
      r.kind      = RESP_ALLOC;                 // free list hands ways out in order
      r.way       = FREE_BASE_WAY + WAY_W'(m_used);
      m_alloc[id] = 1'b1;
      m_way[id]   = r.way;
      m_used++;
    end else begin
      r.kind = RESP_NOFREE;
    end
    return r;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_kind(input resp_kind_e got, input resp_kind_e exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t: resp.kind got %s expected %s",
                         $time, got.name(), exp.name()));
    end
  endtask

  task automatic check_way(input logic [WAY_W-1:0] got, input logic [WAY_W-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t: resp.way got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_hppa(input logic [HPPA_W-1:0] got, input logic [HPPA_W-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t: resp.hppa got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t: lkup_ready got %b expected %b", $time, got, exp));
    end
  endtask

  // mid-cycle sampling where inputs and outputs are settled
  always @(negedge clk_i) begin
    // the pipeline only refuses a lookup when every slot holds one
    check_ready(lkup_ready, exp_q.size() < MAX_IN_FLIGHT);
    lkup_fire = lkup_valid && lkup_ready;
    if (lkup_valid && !lkup_ready) blocked_seen = 1'b1;
    if (resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        fail_now($sformatf("response at %0t with no lookup outstanding", $time));
      end else begin
        exp_r = exp_q.pop_front();
        check_hppa(resp.hppa, exp_r.hppa);
        check_kind(resp.kind, exp_r.kind);
        if (exp_r.kind == RESP_HIT || exp_r.kind == RESP_ALLOC) check_way(resp.way, exp_r.way);
        kind_seen[int'(exp_r.kind)]++;
      end
    end
    if (lkup_fire) begin
      exp_q.push_back(predict(lkup.hppa));
      n_sent++;
    end
    if (exp_q.size() > MAX_IN_FLIGHT) fail_now("more lookups in flight than the pipeline holds");
  end

  task automatic apply_reset();
    lkup_valid = 1'b0;
    resp_ready = 1'b0;
    rst_ni     = 1'b0;
    for (int i = 0; i < ATT_ENTRIES; i++) begin
      m_alloc[i] = 1'b0;
      m_way[i]   = '0;
    end
    m_used = 0;
    exp_q.delete();                             // in-flight lookups die with the reset
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
  endtask

  // one cycle of traffic with the payload held until its transfer
  task automatic drive_cycle(input int limit, input logic hold_resp);
    @(posedge clk_i);
    #10;
    if (lkup_valid && !lkup_fire) begin
      lkup_valid = 1'b1;
    end else if (n_sent < limit && rand_bits(2) != 0) begin
      lkup_valid = 1'b1;
      lkup.hppa  = pick_hppa();
    end else begin
      lkup_valid = 1'b0;
    end
    resp_ready = hold_resp ? 1'b0 : (rand_bits(3) != 0); // one cycle in eight stalled
  endtask

  task automatic run_traffic(input int limit);
    while (n_sent < limit) drive_cycle(limit, 1'b0);
  endtask

  task automatic offer_page(input logic [HPPA_W-1:0] hppa);
    @(posedge clk_i);
    #10;
    lkup_valid = 1'b1;
    lkup.hppa  = hppa;
    resp_ready = 1'b1;
    do begin
      @(posedge clk_i);
      #10;
    end while (!lkup_fire);
    lkup_valid = 1'b0;
  endtask

  initial begin
    #((TOTAL_LKUPS * WORST_CYC + MARGIN_CYC) * CLK_PERIOD);
    fail_now("timeout, responses stopped coming");
  end

  initial begin
    lkup         = '0;
    lkup_valid   = 1'b0;
    resp_ready   = 1'b0;
    lkup_fire    = 1'b0;
    blocked_seen = 1'b0;
    n_sent       = 0;
    apply_reset();
    offer_page(HPPA_BASE + 12'd2);              // allocates the base way
    offer_page(HPPA_BASE + 12'd2);              // same page now hits
    offer_page(HPPA_BASE + HPPA_W'(ATT_ENTRIES)); // just past the window
    run_traffic(100);
    repeat (24) drive_cycle(150, 1'b1);         // long host stall fills the pipe
    run_traffic(150);
    apply_reset();
    offer_page(HPPA_BASE + 12'd7);              // fresh tables give the base way again
    run_traffic(TOTAL_LKUPS);
    while (exp_q.size() != 0) drive_cycle(TOTAL_LKUPS, 1'b0);
    repeat (10) drive_cycle(TOTAL_LKUPS, 1'b0);
    if (!blocked_seen || kind_seen[0] == 0 || kind_seen[1] == 0 ||
        kind_seen[2] == 0 || kind_seen[3] == 0) begin
      fail_now("a response kind or lookup back-pressure was never seen");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: hawk_pgrd_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake and table port assertions, bound into the page read top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hawk_pgrd_props (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        lkup_valid,
  input logic                        lkup_ready,
  input hawk_pgrd_pkg::trnsl_resp_t  resp,
  input logic                        resp_valid,
  input logic                        resp_ready,
  input hawk_pgrd_pkg::tbl_rd_req_t  tbl_rd,
  input logic                        tbl_rd_valid,
  input logic                        free_empty,
  input logic                        q_full
);
  import hawk_pgrd_pkg::*;

  // a stalled response keeps valid and payload
  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else $error("resp changed or dropped while stalled");

  // room in the queue means the front end can take a lookup
  lkup_room_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !q_full |-> lkup_ready)
    else $error("lkup_ready low with queue not full");

  free_pop_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl_rd_valid && tbl_rd.sel == SEL_FREE |-> !free_empty)
    else $error("free list pop issued on an empty free list");

  // host ports stay quiet in reset
  rst_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> !(lkup_valid && lkup_ready) && !(resp_valid && resp_ready))
    else $error("host transfer while in reset");

endmodule

bind hawk_pgrd hawk_pgrd_props u_props (
  .clk_i, .rst_ni, .lkup_valid, .lkup_ready,
  .resp, .resp_valid, .resp_ready,
  .tbl_rd, .tbl_rd_valid, .free_empty,
  .q_full (u_queue.full)
);

// File: hawk_pgrd.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// page read top: front end, request queue, manager and table store
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hawk_pgrd (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  hawk_pgrd_pkg::lkup_req_t    lkup,
  input  logic                        lkup_valid,
  output logic                        lkup_ready,
  output hawk_pgrd_pkg::trnsl_resp_t  resp,
  output logic                        resp_valid,
  input  logic                        resp_ready
);
  import hawk_pgrd_pkg::*;

  pgrd_req_t   q_in;          // front end to queue
  logic        q_in_valid;
  logic        q_in_ready;
  pgrd_req_t   q_out;         // queue to manager
  logic        q_out_valid;
  logic        q_out_ready;
  tbl_rd_req_t tbl_rd;
  logic        tbl_rd_valid;
  att_entry_t  tbl_rd_data;
  tbl_wr_t     tbl_wr;
  logic        tbl_wr_valid;
  logic        free_empty;

  lkup_front u_front (
    .clk_i, .rst_ni,
    .lkup, .lkup_valid, .lkup_ready,
    .q_in, .q_in_valid, .q_in_ready
  );

  lkup_queue u_queue (
    .clk_i, .rst_ni,
    .q_in, .q_in_valid, .q_in_ready,
    .q_out, .q_out_valid, .q_out_ready
  );

  pgrd_mngr u_mngr (
    .clk_i, .rst_ni,
    .q_out, .q_out_valid, .q_out_ready,
    .tbl_rd, .tbl_rd_valid, .tbl_rd_data, .free_empty,
    .tbl_wr, .tbl_wr_valid,
    .resp, .resp_valid, .resp_ready
  );

  tbl_store u_store (
    .clk_i, .rst_ni,
    .tbl_rd, .tbl_rd_valid, .tbl_rd_data,
    .tbl_wr, .tbl_wr_valid,
    .free_empty
  );

endmodule

// File: tbl_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// on-chip ATT and free list with a one-cycle read port that pops the
// free list head and an ATT write port driven by the page read manager
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tbl_store (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  hawk_pgrd_pkg::tbl_rd_req_t  tbl_rd,
  input  logic                        tbl_rd_valid,
  output hawk_pgrd_pkg::att_entry_t   tbl_rd_data,
  input  hawk_pgrd_pkg::tbl_wr_t      tbl_wr,
  input  logic                        tbl_wr_valid,
  output logic                        free_empty
);
  import hawk_pgrd_pkg::*;

  att_entry_t            att_mem  [ATT_ENTRIES];
  logic [WAY_W-1:0]      free_way [FREE_WAYS];
  logic [FREE_PTR_W-1:0] free_head;
  logic                  pop;
  att_entry_t            rd_d;

  // pops come only while the list is not empty
  assign pop        = tbl_rd_valid & (tbl_rd.sel == SEL_FREE);
  assign free_empty = free_head == FREE_PTR_W'(FREE_WAYS);

  // ATT entries all deallocated out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < ATT_ENTRIES; i++) begin
        att_mem[i] <= '{sts: STS_DALLOC, way: '0};
      end
    end else if (tbl_wr_valid) begin
      att_mem[tbl_wr.att_id] <= tbl_wr.entry; // visible to the next read
    end
  end

  // free list holds consecutive ways from the base
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < FREE_WAYS; i++) begin
        free_way[i] <= FREE_BASE_WAY + WAY_W'(i);
      end
    end
  end

  // head pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_head <= '0;
    end else if (pop) begin
      free_head <= free_head + 1'b1;
    end
  end

  always_comb begin
    if (tbl_rd.sel == SEL_FREE) begin
      rd_d.sts = STS_DALLOC; // sts has no meaning for a free entry
      rd_d.way = free_way[free_head[FREE_IDX_W-1:0]];
    end else begin
      rd_d = att_mem[tbl_rd.att_id];
    end
  end

  // registered read data valid the cycle after the request
  always_ff @(posedge clk_i) begin
    if (tbl_rd_valid) tbl_rd_data <= rd_d;
  end

endmodule

// File: pgrd_mngr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// page read manager FSM: reads the ATT entry, pops a free way for a
// deallocated page, updates the table and returns the response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pgrd_mngr (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // request queue
  input  hawk_pgrd_pkg::pgrd_req_t    q_out,
  input  logic                        q_out_valid,
  output logic                        q_out_ready,
  // table read port
  output hawk_pgrd_pkg::tbl_rd_req_t  tbl_rd,
  output logic                        tbl_rd_valid,
  input  hawk_pgrd_pkg::att_entry_t   tbl_rd_data,
  input  logic                        free_empty,
  // table write port
  output hawk_pgrd_pkg::tbl_wr_t      tbl_wr,
  output logic                        tbl_wr_valid,
  // host response
  output hawk_pgrd_pkg::trnsl_resp_t  resp,
  output logic                        resp_valid,
  input  logic                        resp_ready
);
  import hawk_pgrd_pkg::*;

  pgrd_state_e         state_q;
  pgrd_state_e         state_d;
  logic [ATT_ID_W-1:0] att_id_q;   // entry under service
  att_entry_t          att_q;      // entry as read from the ATT
  trnsl_resp_t         resp_q;
  trnsl_resp_t         resp_d;
  logic                req_take;

  assign q_out_ready = state_q == IDLE; // one request at a time
  assign req_take    = q_out_valid & q_out_ready;

  // next state and response build-up
  always_comb begin
    state_d = state_q;
    resp_d  = resp_q;
    case (state_q)
      IDLE: begin
        if (q_out_valid) begin
          resp_d.hppa = q_out.hppa;
          resp_d.way  = '0;
          if (q_out.in_window) begin
            state_d = RD_ATT;
          end else begin
            resp_d.kind = RESP_RANGE; // outside window, no table access
            state_d     = RESPOND;
          end
        end
      end
      RD_ATT:   state_d = WAIT_ATT;   // read issued this cycle
      WAIT_ATT: state_d = CHK_ATT;    // data lands, captured in att_q
      CHK_ATT: begin
        if (att_q.sts == STS_UNCOMP || att_q.sts == STS_INCOMP) begin
          resp_d.kind = RESP_HIT;
          resp_d.way  = att_q.way;
          state_d     = RESPOND;
        end else if (!free_empty) begin
          state_d = POP_FREE;         // deallocated, grab a way
        end else begin
          resp_d.kind = RESP_NOFREE;  // nothing left, table untouched
          state_d     = RESPOND;
        end
      end
      POP_FREE: state_d = WAIT_FREE;
      WAIT_FREE: begin
        resp_d.way = tbl_rd_data.way; // only way is valid on a free read
        state_d    = TBL_UPDATE;
      end
      TBL_UPDATE: begin
        resp_d.kind = RESP_ALLOC;
        state_d     = RESPOND;
      end
      RESPOND: begin
        if (resp_ready) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // payload regs
  always_ff @(posedge clk_i) begin
    resp_q <= resp_d;
    if (req_take) att_id_q <= q_out.att_id;
    if (state_q == WAIT_ATT) att_q <= tbl_rd_data;
  end

  // table read, ATT first then free list head
  assign tbl_rd_valid  = (state_q == RD_ATT) | (state_q == POP_FREE);
  assign tbl_rd.sel    = (state_q == POP_FREE) ? SEL_FREE : SEL_ATT;
  assign tbl_rd.att_id = att_id_q;

  // new entry points at the popped way
  assign tbl_wr_valid    = state_q == TBL_UPDATE;
  assign tbl_wr.att_id   = att_id_q;
  assign tbl_wr.entry.sts = STS_UNCOMP;
  assign tbl_wr.entry.way = resp_q.way;

  assign resp_valid = state_q == RESPOND;
  assign resp       = resp_q;

endmodule

// File: lkup_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order request FIFO between the lookup front end and the
// page read manager, valid/ready on both sides
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lkup_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  hawk_pgrd_pkg::pgrd_req_t  q_in,
  input  logic                      q_in_valid,
  output logic                      q_in_ready,
  output hawk_pgrd_pkg::pgrd_req_t  q_out,
  output logic                      q_out_valid,
  input  logic                      q_out_ready
);
  import hawk_pgrd_pkg::*;

  pgrd_req_t         mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QCNT_W-1:0] count;
  logic              full;
  logic              push;
  logic              pop;

  assign full        = count == QCNT_W'(QUEUE_DEPTH);
  assign q_out_valid = count != '0;
  assign q_out       = mem[rd_ptr];   // head entry, shows one cycle after write

  // a pop in the same cycle frees the slot for a push
  assign q_in_ready = ~full | q_out_ready;
  assign push       = q_in_valid & q_in_ready;
  assign pop        = q_out_valid & q_out_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps itself
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // none or both
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr] <= q_in;
  end

endmodule

// File: lkup_front.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lookup front end, maps a host page number to an ATT entry id
// and registers the request packet toward the request queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lkup_front (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  hawk_pgrd_pkg::lkup_req_t  lkup,
  input  logic                      lkup_valid,
  output logic                      lkup_ready,
  output hawk_pgrd_pkg::pgrd_req_t  q_in,
  output logic                      q_in_valid,
  input  logic                      q_in_ready
);
  import hawk_pgrd_pkg::*;

  logic [HPPA_W-1:0] hppa_off;  // offset from window base
  pgrd_req_t         req_d;
  logic              take;

  // wraps below the base, so one unsigned compare covers both ends
  assign hppa_off = lkup.hppa - HPPA_BASE;

  always_comb begin
    req_d.hppa      = lkup.hppa;
    req_d.att_id    = hppa_off[ATT_ID_W-1:0];
    req_d.in_window = hppa_off < HPPA_W'(ATT_ENTRIES);
  end

  // slice is free when empty or draining this cycle
  assign lkup_ready = q_in_ready | ~q_in_valid;
  assign take       = lkup_valid & lkup_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q_in_valid <= 1'b0;
    end else if (take) begin
      q_in_valid <= 1'b1;
    end else if (q_in_ready) begin
      q_in_valid <= 1'b0; // packet left, nothing new
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) q_in <= req_d;
  end

endmodule

// File: hawk_pgrd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared sizes, enums and packet structs for the page read side
// imported by every block of the page read path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hawk_pgrd_pkg;

  // host page numbers and managed window
  localparam int unsigned HPPA_W = 12;
  localparam logic [HPPA_W-1:0] HPPA_BASE = 12'h200; // first managed page
  localparam int unsigned ATT_ENTRIES = 16;
  localparam int unsigned ATT_ID_W = 4;

  // physical ways and free list
  localparam int unsigned WAY_W = 8;
  localparam int unsigned FREE_WAYS = 8;
  localparam logic [WAY_W-1:0] FREE_BASE_WAY = 8'h40; // way in free entry 0
  localparam int unsigned FREE_PTR_W = 4;   // one wider, so head can reach FREE_WAYS
  localparam int unsigned FREE_IDX_W = 3;   // index into free way array

  // request queue
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QPTR_W = 2;
  localparam int unsigned QCNT_W = 3;       // holds 0..QUEUE_DEPTH

  typedef enum logic [1:0] {
    STS_DALLOC = 2'd0, // no way behind the entry
    STS_UNCOMP = 2'd1,
    STS_INCOMP = 2'd2  // incompressible, still a plain way
  } att_sts_e;

  typedef struct packed {
    att_sts_e         sts;
    logic [WAY_W-1:0] way;
  } att_entry_t; // 10 bits

  typedef enum logic {
    SEL_ATT  = 1'b0,
    SEL_FREE = 1'b1
  } tbl_sel_e;

  typedef struct packed {
    logic [HPPA_W-1:0] hppa;
  } lkup_req_t;

  typedef struct packed {
    logic [HPPA_W-1:0]   hppa;
    logic [ATT_ID_W-1:0] att_id;
    logic                in_window;
  } pgrd_req_t;

  typedef struct packed {
    tbl_sel_e            sel;
    logic [ATT_ID_W-1:0] att_id; // ignored for free list reads
  } tbl_rd_req_t;

  typedef struct packed {
    logic [ATT_ID_W-1:0] att_id;
    att_entry_t          entry;
  } tbl_wr_t;

  typedef enum logic [1:0] {
    RESP_HIT    = 2'd0,
    RESP_ALLOC  = 2'd1,
    RESP_NOFREE = 2'd2,
    RESP_RANGE  = 2'd3
  } resp_kind_e;

  typedef struct packed {
    logic [HPPA_W-1:0] hppa;
    resp_kind_e        kind;
    logic [WAY_W-1:0]  way;
  } trnsl_resp_t;

  typedef enum logic [2:0] {
    IDLE, RD_ATT, WAIT_ATT, CHK_ATT, POP_FREE, WAIT_FREE, TBL_UPDATE, RESPOND
  } pgrd_state_e;

endpackage
